// ==== verilog/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and address width
`define CPU_WIDTH 16

// architectural register count, R7 is the link register
`define CPU_NREGS 8

// bits needed to index one register
`define CPU_RADDR 3

// first fetch address after reset
`define CPU_RESET_PC 0

`endif

// ==== verilog/cpuPkg.sv ====
`default_nettype none
`include "cpu_macros.svh"

package cpuPkg;

    typedef logic [`CPU_WIDTH-1:0] word_t;
    typedef logic [`CPU_WIDTH-1:0] instr_t;
    typedef logic [`CPU_RADDR-1:0] regAddr_t;
    typedef logic [4:0]            opcode_t;
    typedef logic [1:0]            func_t;
    typedef logic [3:0]            aluOp_t;

    // alu operation codes, 4'b0110 and 4'b1000 unused
    localparam aluOp_t rol    = 4'b0000;
    localparam aluOp_t sll    = 4'b0001;
    localparam aluOp_t ror    = 4'b0010;
    localparam aluOp_t srl    = 4'b0011;
    localparam aluOp_t add    = 4'b0100;
    localparam aluOp_t andOp  = 4'b0101;
    localparam aluOp_t xorOp  = 4'b0111;
    localparam aluOp_t seq    = 4'b1001;
    localparam aluOp_t slt    = 4'b1010;
    localparam aluOp_t sco    = 4'b1011;
    localparam aluOp_t sle    = 4'b1100;
    localparam aluOp_t passB  = 4'b1101;
    localparam aluOp_t slbiOr = 4'b1110;
    localparam aluOp_t btr    = 4'b1111;

    typedef struct packed {
        logic [1:0] regDst;     // 00 rt, 01 rs, 10 rd, 11 r7
        logic [1:0] memToReg;   // 00 pc+2, 01 memory, 10 alu
        logic [1:0] aluSrc1;    // 00 rs, 01 zero, 10 rs << 8
        logic [1:0] aluSrc2;    // 00 rt, 01 imm5, 10 imm8, 11 zero
        aluOp_t     aluOp;
        logic       zeroExt;
        logic       immSrc;     // 11-bit displacement jump
        logic       aluJump;    // jr / jalr target from alu
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        logic       invA;
        logic       invB;
        logic       cin;
        logic       beq;
        logic       bne;
        logic       blt;
        logic       bge;
        logic       halt;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/control.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module control (
    input  cpuPkg::instr_t instr,
    output cpuPkg::ctrl_t  ctrl,
    output logic           err
);

    cpuPkg::opcode_t opcode;
    cpuPkg::func_t   func;

    assign opcode = instr[15:11];
    assign func   = instr[1:0];

    always_comb begin
        // most instructions write an alu result to a register
        ctrl          = '0;
        ctrl.memToReg = 2'b10;
        ctrl.aluOp    = cpuPkg::add;
        ctrl.regWrite = 1'b1;
        err           = 1'b0;

        case (opcode)
            5'b00000: begin
                ctrl.halt     = 1'b1;
                ctrl.regWrite = 1'b0;
            end
            5'b00001: begin
                ctrl.regWrite = 1'b0;
            end
            5'b01000: begin
                ctrl.aluSrc2 = 2'b01;
            end
            // subi is imm - rs
            5'b01001: begin
                ctrl.aluSrc2 = 2'b01;
                ctrl.invA    = 1'b1;
                ctrl.cin     = 1'b1;
            end
            5'b01010: begin
                ctrl.aluSrc2 = 2'b01;
                ctrl.zeroExt = 1'b1;
                ctrl.aluOp   = cpuPkg::xorOp;
            end
            5'b01011: begin
                ctrl.aluSrc2 = 2'b01;
                ctrl.zeroExt = 1'b1;
                ctrl.aluOp   = cpuPkg::andOp;
                ctrl.invB    = 1'b1;
            end
            // roli, slli, rori, srli map straight onto alu codes 0..3
            5'b10100, 5'b10101, 5'b10110, 5'b10111: begin
                ctrl.aluSrc2 = 2'b01;
                ctrl.zeroExt = 1'b1;
                ctrl.aluOp   = {2'b00, opcode[1:0]};
            end
            5'b10000: begin
                ctrl.aluSrc2  = 2'b01;
                ctrl.regWrite = 1'b0;
                ctrl.memWrite = 1'b1;
            end
            5'b10001: begin
                ctrl.aluSrc2  = 2'b01;
                ctrl.memToReg = 2'b01;
                ctrl.memRead  = 1'b1;
            end
            // stu writes the effective address back into rs
            5'b10011: begin
                ctrl.regDst   = 2'b01;
                ctrl.aluSrc2  = 2'b01;
                ctrl.memWrite = 1'b1;
            end
            5'b11001: begin
                ctrl.regDst = 2'b10;
                ctrl.aluOp  = cpuPkg::btr;
            end
            5'b11011: begin
                ctrl.regDst = 2'b10;
                case (func)
                    2'b00: ctrl.aluOp = cpuPkg::add;
                    2'b01: begin
                        ctrl.invA = 1'b1;
                        ctrl.cin  = 1'b1;
                    end
                    2'b10: ctrl.aluOp = cpuPkg::xorOp;
                    default: begin
                        ctrl.aluOp = cpuPkg::andOp;
                        ctrl.invB  = 1'b1;
                    end
                endcase
            end
            5'b11010: begin
                ctrl.regDst = 2'b10;
                ctrl.aluOp  = {2'b00, func};
            end
            // compares run rs - rt through the adder
            5'b11100, 5'b11101, 5'b11110: begin
                ctrl.regDst = 2'b10;
                ctrl.invB   = 1'b1;
                ctrl.cin    = 1'b1;
                case (opcode[1:0])
                    2'b00:   ctrl.aluOp = cpuPkg::seq;
                    2'b01:   ctrl.aluOp = cpuPkg::slt;
                    default: ctrl.aluOp = cpuPkg::sle;
                endcase
            end
            5'b11111: begin
                ctrl.regDst = 2'b10;
                ctrl.aluOp  = cpuPkg::sco;
            end
            // beqz, bnez, bltz, bgez
            5'b01100, 5'b01101, 5'b01110, 5'b01111: begin
                ctrl.aluSrc2  = 2'b11;
                ctrl.regWrite = 1'b0;
                ctrl.beq      = (opcode[1:0] == 2'b00);
                ctrl.bne      = (opcode[1:0] == 2'b01);
                ctrl.blt      = (opcode[1:0] == 2'b10);
                ctrl.bge      = (opcode[1:0] == 2'b11);
            end
            5'b11000: begin
                ctrl.regDst  = 2'b01;
                ctrl.aluSrc1 = 2'b01;
                ctrl.aluSrc2 = 2'b10;
            end
            5'b10010: begin
                ctrl.regDst  = 2'b01;
                ctrl.aluSrc1 = 2'b10;
                ctrl.aluSrc2 = 2'b10;
                ctrl.zeroExt = 1'b1;
                ctrl.aluOp   = cpuPkg::slbiOr;
            end
            5'b00100: begin
                ctrl.regWrite = 1'b0;
                ctrl.immSrc   = 1'b1;
                ctrl.aluOp    = cpuPkg::passB;
            end
            5'b00101: begin
                ctrl.aluSrc2  = 2'b10;
                ctrl.regWrite = 1'b0;
                ctrl.aluJump  = 1'b1;
            end
            5'b00110: begin
                ctrl.regDst   = 2'b11;
                ctrl.memToReg = 2'b00;
                ctrl.immSrc   = 1'b1;
                ctrl.aluOp    = cpuPkg::passB;
            end
            5'b00111: begin
                ctrl.regDst   = 2'b11;
                ctrl.memToReg = 2'b00;
                ctrl.aluSrc2  = 2'b10;
                ctrl.aluJump  = 1'b1;
            end
            default: begin
                err           = 1'b1;
                ctrl.regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::regAddr_t rdAddrA,
    input  cpuPkg::regAddr_t rdAddrB,
    output cpuPkg::word_t    rdDataA,
    output cpuPkg::word_t    rdDataB,
    input  logic             wrEn,
    input  cpuPkg::regAddr_t wrAddr,
    input  cpuPkg::word_t    wrData
);

    cpuPkg::word_t regs [`CPU_NREGS];

    // reads see the old value during a same-cycle write
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module alu (
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    input  cpuPkg::aluOp_t aluOp,
    input  logic           invA,
    input  logic           invB,
    input  logic           cin,
    output cpuPkg::word_t  result
);

    localparam int shiftW = $clog2(`CPU_WIDTH);

    cpuPkg::word_t           aIn;
    cpuPkg::word_t           bIn;
    cpuPkg::word_t           revA;
    logic [`CPU_WIDTH:0]     sum;
    logic [2*`CPU_WIDTH-1:0] rotL;
    logic [2*`CPU_WIDTH-1:0] rotR;
    logic [shiftW-1:0]       shamt;
    logic                    overflow;
    logic                    lessThan;
    logic                    isZero;

    assign aIn = invA ? ~a : a;
    assign bIn = invB ? ~b : b;

    // one adder serves add, subtract, compare and carry-out
    assign sum = {1'b0, aIn} + {1'b0, bIn} + {{`CPU_WIDTH{1'b0}}, cin};

    // signed less-than from the sign of a - b corrected for overflow
    assign overflow = (aIn[`CPU_WIDTH-1] == bIn[`CPU_WIDTH-1]) &&
                      (sum[`CPU_WIDTH-1] != aIn[`CPU_WIDTH-1]);
    assign lessThan = sum[`CPU_WIDTH-1] ^ overflow;
    assign isZero   = (sum[`CPU_WIDTH-1:0] == '0);

    // rotates via a doubled copy of a
    assign shamt = bIn[shiftW-1:0];
    assign rotL  = {aIn, aIn} << shamt;
    assign rotR  = {aIn, aIn} >> shamt;

    always_comb begin
        for (int i = 0; i < `CPU_WIDTH; i++) begin
            revA[i] = aIn[`CPU_WIDTH-1-i];
        end
    end

    always_comb begin
        case (aluOp)
            cpuPkg::rol:    result = rotL[2*`CPU_WIDTH-1:`CPU_WIDTH];
            cpuPkg::sll:    result = aIn << shamt;
            cpuPkg::ror:    result = rotR[`CPU_WIDTH-1:0];
            cpuPkg::srl:    result = aIn >> shamt;
            cpuPkg::add:    result = sum[`CPU_WIDTH-1:0];
            cpuPkg::andOp:  result = aIn & bIn;
            cpuPkg::xorOp:  result = aIn ^ bIn;
            cpuPkg::seq:    result = cpuPkg::word_t'(isZero);
            cpuPkg::slt:    result = cpuPkg::word_t'(lessThan);
            cpuPkg::sle:    result = cpuPkg::word_t'(lessThan | isZero);
            cpuPkg::sco:    result = cpuPkg::word_t'(sum[`CPU_WIDTH]);
            cpuPkg::passB:  result = bIn;
            cpuPkg::slbiOr: result = aIn | bIn;
            cpuPkg::btr:    result = revA;
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/execCore.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module execCore (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::instr_t   instr,
    input  logic             instrValid,
    output cpuPkg::word_t    memAddr,
    output cpuPkg::word_t    memWData,
    output logic             memRead,
    output logic             memWrite,
    input  cpuPkg::word_t    memRData,
    output cpuPkg::word_t    pc,
    output logic             halted,
    output logic             err,
    output logic             wbEn,
    output cpuPkg::regAddr_t wbReg,
    output cpuPkg::word_t    wbData
);

    cpuPkg::ctrl_t    ctrl;
    logic             decErr;
    logic             active;
    logic             branchTaken;
    cpuPkg::regAddr_t rsAddr;
    cpuPkg::regAddr_t rtAddr;
    cpuPkg::regAddr_t rdAddr;
    cpuPkg::word_t    rsData;
    cpuPkg::word_t    rtData;
    cpuPkg::word_t    imm5Ext;
    cpuPkg::word_t    imm8Ext;
    cpuPkg::word_t    disp11Ext;
    cpuPkg::word_t    opA;
    cpuPkg::word_t    opB;
    cpuPkg::word_t    aluResult;
    cpuPkg::word_t    pcPlus2;
    cpuPkg::word_t    pcNext;

    assign active = instrValid && !halted;
    assign rsAddr = instr[10:8];
    assign rtAddr = instr[7:5];
    assign rdAddr = instr[4:2];

    control control_i (
        .instr (instr),
        .ctrl  (ctrl),
        .err   (decErr)
    );

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (rsAddr),
        .rdAddrB (rtAddr),
        .rdDataA (rsData),
        .rdDataB (rtData),
        .wrEn    (wbEn),
        .wrAddr  (wbReg),
        .wrData  (wbData)
    );

    assign imm5Ext = ctrl.zeroExt ? {{(`CPU_WIDTH-5){1'b0}}, instr[4:0]}
                                  : {{(`CPU_WIDTH-5){instr[4]}}, instr[4:0]};
    assign imm8Ext = ctrl.zeroExt ? {{(`CPU_WIDTH-8){1'b0}}, instr[7:0]}
                                  : {{(`CPU_WIDTH-8){instr[7]}}, instr[7:0]};
    assign disp11Ext = {{(`CPU_WIDTH-11){instr[10]}}, instr[10:0]};

    always_comb begin
        case (ctrl.aluSrc1)
            2'b01:   opA = '0;
            2'b10:   opA = rsData << 8;
            default: opA = rsData;
        endcase
        case (ctrl.aluSrc2)
            2'b01:   opB = imm5Ext;
            2'b10:   opB = imm8Ext;
            2'b11:   opB = '0;
            default: opB = rtData;
        endcase
    end

    alu alu_i (
        .a      (opA),
        .b      (opB),
        .aluOp  (ctrl.aluOp),
        .invA   (ctrl.invA),
        .invB   (ctrl.invB),
        .cin    (ctrl.cin),
        .result (aluResult)
    );

    // data memory port, store data always comes from bits 7-5
    assign memAddr  = aluResult;
    assign memWData = rtData;
    assign memRead  = active && ctrl.memRead;
    assign memWrite = active && ctrl.memWrite;

    assign pcPlus2 = pc + cpuPkg::word_t'(2);

    always_comb begin
        case (ctrl.regDst)
            2'b00:   wbReg = rtAddr;
            2'b01:   wbReg = rsAddr;
            2'b10:   wbReg = rdAddr;
            default: wbReg = cpuPkg::regAddr_t'(`CPU_NREGS - 1);
        endcase
        case (ctrl.memToReg)
            2'b00:   wbData = pcPlus2;
            2'b01:   wbData = memRData;
            default: wbData = aluResult;
        endcase
    end

    assign wbEn = active && ctrl.regWrite && !decErr;
    assign err  = active && decErr;

    // branch conditions look at rs only
    assign branchTaken = (ctrl.beq && (rsData == '0)) ||
                         (ctrl.bne && (rsData != '0)) ||
                         (ctrl.blt && rsData[`CPU_WIDTH-1]) ||
                         (ctrl.bge && !rsData[`CPU_WIDTH-1]);

    always_comb begin
        if (ctrl.aluJump) begin
            pcNext = aluResult;
        end else if (ctrl.immSrc) begin
            pcNext = pcPlus2 + disp11Ext;
        end else if (branchTaken) begin
            pcNext = pcPlus2 + imm8Ext;
        end else begin
            pcNext = pcPlus2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc     <= cpuPkg::word_t'(`CPU_RESET_PC);
            halted <= 1'b0;
        end else if (active) begin
            pc <= pcNext;
            if (ctrl.halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tbExecCore.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module tbExecCore;

    // about 300 instructions issued at one per cycle
    localparam int maxCycles = 2000;

    logic             clk;
    logic             rstN;
    cpuPkg::instr_t   instr;
    logic             instrValid;
    cpuPkg::word_t    memAddr;
    cpuPkg::word_t    memWData;
    logic             memRead;
    logic             memWrite;
    cpuPkg::word_t    memRData;
    cpuPkg::word_t    pc;
    logic             halted;
    logic             err;
    logic             wbEn;
    cpuPkg::regAddr_t wbReg;
    cpuPkg::word_t    wbData;

    // data memory seen by the DUT and its reference copy
    cpuPkg::word_t mem [256];
    cpuPkg::word_t expMem [256];

    // architectural reference state
    cpuPkg::word_t regsM [`CPU_NREGS];
    cpuPkg::word_t pcM;
    logic          haltedM;

    // predicted response of the instruction in flight
    logic             expWbEn;
    cpuPkg::regAddr_t expWbReg;
    cpuPkg::word_t    expWbData;
    logic             expMemRead;
    logic             expMemWrite;
    logic             expErr;
    logic             expHalt;
    cpuPkg::word_t    expAddr;
    cpuPkg::word_t    expStoreData;
    cpuPkg::word_t    expNextPc;

    int errorCount;
    int checkCount;
    int cycleCount = 0;
    int seedVal;

    execCore execCore_i (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .memAddr    (memAddr),
        .memWData   (memWData),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memRData   (memRData),
        .pc         (pc),
        .halted     (halted),
        .err        (err),
        .wbEn       (wbEn),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // word addressed memory drops bit 0 of the byte address
    assign memRData = mem[memAddr[8:1]];

    always @(posedge clk) begin
        if (memWrite) begin
            mem[memAddr[8:1]] <= memWData;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("timeout: the run did not finish within %0d cycles", maxCycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic cpuPkg::word_t rotLeft(input cpuPkg::word_t v, input int n);
        return (v << n) | (v >> (`CPU_WIDTH - n));
    endfunction

    function automatic cpuPkg::word_t rotRight(input cpuPkg::word_t v, input int n);
        return (v >> n) | (v << (`CPU_WIDTH - n));
    endfunction

    // low bits shifted in first end up at the top
    function automatic cpuPkg::word_t bitReverse(input cpuPkg::word_t v);
        cpuPkg::word_t r;
        r = '0;
        for (int k = 0; k < `CPU_WIDTH; k++) begin
            r = {r[`CPU_WIDTH-2:0], v[k]};
        end
        return r;
    endfunction

    function automatic cpuPkg::instr_t immInstr(input logic [4:0] op, input cpuPkg::regAddr_t rs,
                                                input cpuPkg::regAddr_t rt, input logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpuPkg::instr_t regInstr(input logic [4:0] op, input cpuPkg::regAddr_t rs,
                                                input cpuPkg::regAddr_t rt,
                                                input cpuPkg::regAddr_t rd, input logic [1:0] fn);
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic cpuPkg::instr_t byteInstr(input logic [4:0] op, input cpuPkg::regAddr_t rs,
                                                 input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic cpuPkg::instr_t jumpInstr(input logic [4:0] op, input logic [10:0] disp);
        return {op, disp};
    endfunction

    task automatic expectWord(input string testName, input string what,
                              input cpuPkg::word_t expected, input cpuPkg::word_t actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("ERROR %s: %s expected %h actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic expectBit(input string testName, input string what,
                             input logic expected, input logic actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("ERROR %s: %s expected %b actual %b", testName, what, expected, actual);
        end
    endtask

    task automatic setWb(input cpuPkg::regAddr_t r, input cpuPkg::word_t v);
        expWbEn   = 1'b1;
        expWbReg  = r;
        expWbData = v;
    endtask

    // ISA rules applied to the reference state
    task automatic predict(input cpuPkg::instr_t i, input logic valid);
        cpuPkg::regAddr_t rs;
        cpuPkg::regAddr_t rt;
        cpuPkg::regAddr_t rd;
        cpuPkg::word_t    a;
        cpuPkg::word_t    b;
        cpuPkg::word_t    s5;
        cpuPkg::word_t    z5;
        cpuPkg::word_t    s8;
        cpuPkg::word_t    d11;
        cpuPkg::word_t    link;
        cpuPkg::word_t    sum16;
        rs   = i[10:8];
        rt   = i[7:5];
        rd   = i[4:2];
        a    = regsM[rs];
        b    = regsM[rt];
        s5   = {{11{i[4]}}, i[4:0]};
        z5   = {11'b0, i[4:0]};
        s8   = {{8{i[7]}}, i[7:0]};
        d11  = {{5{i[10]}}, i[10:0]};
        link = pcM + 16'd2;
        expWbEn      = 1'b0;
        expWbReg     = '0;
        expWbData    = '0;
        expMemRead   = 1'b0;
        expMemWrite  = 1'b0;
        expErr       = 1'b0;
        expHalt      = 1'b0;
        expAddr      = a + s5;
        expStoreData = b;
        expNextPc    = link;
        case (i[15:11])
            5'b00000: expHalt = 1'b1;
            5'b00001: begin
                // nop
            end
            5'b01000: setWb(rt, a + s5);
            5'b01001: setWb(rt, s5 - a);
            5'b01010: setWb(rt, a ^ z5);
            5'b01011: setWb(rt, a & ~z5);
            5'b10100: setWb(rt, rotLeft(a, int'(i[3:0])));
            5'b10101: setWb(rt, a << i[3:0]);
            5'b10110: setWb(rt, rotRight(a, int'(i[3:0])));
            5'b10111: setWb(rt, a >> i[3:0]);
            5'b10000: expMemWrite = 1'b1;
            5'b10001: begin
                expMemRead = 1'b1;
                setWb(rt, expMem[expAddr[8:1]]);
            end
            5'b10011: begin
                expMemWrite = 1'b1;
                setWb(rs, expAddr);
            end
            5'b11001: setWb(rd, bitReverse(a));
            5'b11011: case (i[1:0])
                2'b00:   setWb(rd, a + b);
                2'b01:   setWb(rd, b - a);
                2'b10:   setWb(rd, a ^ b);
                default: setWb(rd, a & ~b);
            endcase
            5'b11010: case (i[1:0])
                2'b00:   setWb(rd, rotLeft(a, int'(b[3:0])));
                2'b01:   setWb(rd, a << b[3:0]);
                2'b10:   setWb(rd, rotRight(a, int'(b[3:0])));
                default: setWb(rd, a >> b[3:0]);
            endcase
            5'b11100: setWb(rd, (a == b) ? 16'd1 : 16'd0);
            5'b11101: setWb(rd, ($signed(a) < $signed(b)) ? 16'd1 : 16'd0);
            5'b11110: setWb(rd, ($signed(a) <= $signed(b)) ? 16'd1 : 16'd0);
            5'b11111: begin
                // a carry out shows as a wrapped sum below a
                sum16 = a + b;
                setWb(rd, (sum16 < a) ? 16'd1 : 16'd0);
            end
            5'b01100: expNextPc = (a == '0) ? link + s8 : link;
            5'b01101: expNextPc = (a != '0) ? link + s8 : link;
            5'b01110: expNextPc = a[15] ? link + s8 : link;
            5'b01111: expNextPc = !a[15] ? link + s8 : link;
            5'b11000: setWb(rs, s8);
            5'b10010: setWb(rs, (a << 8) | {8'b0, i[7:0]});
            5'b00100: expNextPc = link + d11;
            5'b00101: expNextPc = a + s8;
            5'b00110: begin
                setWb(3'd7, link);
                expNextPc = link + d11;
            end
            5'b00111: begin
                setWb(3'd7, link);
                expNextPc = a + s8;
            end
            default: expErr = 1'b1;
        endcase
        // no valid instruction or core halted
        if (!(valid && !haltedM)) begin
            expWbEn     = 1'b0;
            expMemRead  = 1'b0;
            expMemWrite = 1'b0;
            expErr      = 1'b0;
            expHalt     = 1'b0;
            expNextPc   = pcM;
        end
    endtask

    // drive one instruction on the edge and check it mid-cycle before updating the model
    task automatic issue(input string testName, input cpuPkg::instr_t i, input logic valid);
        @(posedge clk);
        instr      <= i;
        instrValid <= valid;
        @(negedge clk);
        expectWord(testName, "pc", pcM, pc);
        expectBit(testName, "halted", haltedM, halted);
        predict(i, valid);
        expectBit(testName, "wbEn", expWbEn, wbEn);
        expectBit(testName, "memRead", expMemRead, memRead);
        expectBit(testName, "memWrite", expMemWrite, memWrite);
        expectBit(testName, "err", expErr, err);
        if (expWbEn) begin
            expectWord(testName, "wbReg", cpuPkg::word_t'(expWbReg), cpuPkg::word_t'(wbReg));
            expectWord(testName, "wbData", expWbData, wbData);
        end
        if (expMemRead || expMemWrite) begin
            expectWord(testName, "memAddr", expAddr, memAddr);
        end
        if (expMemWrite) begin
            expectWord(testName, "memWData", expStoreData, memWData);
            expMem[expAddr[8:1]] = expStoreData;
        end
        if (expWbEn) begin
            regsM[expWbReg] = expWbData;
        end
        pcM = expNextPc;
        if (expHalt) begin
            haltedM = 1'b1;
        end
    endtask

    // lbi then slbi builds any 16-bit value
    task automatic loadReg(input string testName, input cpuPkg::regAddr_t r,
                           input cpuPkg::word_t v);
        issue(testName, byteInstr(5'b11000, r, v[15:8]), 1'b1);
        issue(testName, byteInstr(5'b10010, r, v[7:0]), 1'b1);
    endtask

    task automatic applyReset();
        @(posedge clk);
        rstN       <= 1'b0;
        instrValid <= 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        for (int k = 0; k < `CPU_NREGS; k++) begin
            regsM[k] = '0;
        end
        pcM     = cpuPkg::word_t'(`CPU_RESET_PC);
        haltedM = 1'b0;
    endtask

    task automatic scanMemory(input string testName);
        for (int k = 0; k < 256; k++) begin
            expectWord(testName, $sformatf("mem[%0d]", k), expMem[k], mem[k]);
        end
    endtask

    task automatic immediateOps();
        logic [4:0] ops [8];
        ops = '{5'b01000, 5'b01001, 5'b01010, 5'b01011,
                5'b10100, 5'b10101, 5'b10110, 5'b10111};
        for (int n = 0; n < 6; n++) begin
            loadReg("lbi/slbi", cpuPkg::regAddr_t'($urandom), cpuPkg::word_t'($urandom));
            loadReg("lbi/slbi", cpuPkg::regAddr_t'($urandom), cpuPkg::word_t'($urandom));
            for (int k = 0; k < 8; k++) begin
                issue($sformatf("imm op %b", ops[k]),
                      immInstr(ops[k], cpuPkg::regAddr_t'($urandom),
                               cpuPkg::regAddr_t'($urandom), 5'($urandom)), 1'b1);
            end
        end
    endtask

    task automatic registerOps();
        logic [6:0]       ops [13];
        cpuPkg::regAddr_t r;
        // opcode then func
        ops = '{7'b11011_00, 7'b11011_01, 7'b11011_10, 7'b11011_11,
                7'b11010_00, 7'b11010_01, 7'b11010_10, 7'b11010_11,
                7'b11001_00, 7'b11100_00, 7'b11101_00, 7'b11110_00, 7'b11111_00};
        for (int n = 0; n < 6; n++) begin
            for (int m = 0; m < 3; m++) begin
                loadReg("R setup", cpuPkg::regAddr_t'($urandom), cpuPkg::word_t'($urandom));
            end
            for (int k = 0; k < 13; k++) begin
                issue($sformatf("R op %b func %b", ops[k][6:2], ops[k][1:0]),
                      regInstr(ops[k][6:2], cpuPkg::regAddr_t'($urandom),
                               cpuPkg::regAddr_t'($urandom), cpuPkg::regAddr_t'($urandom),
                               ops[k][1:0]), 1'b1);
            end
            // equal operands make seq and sle true
            r = cpuPkg::regAddr_t'($urandom);
            issue("seq equal", regInstr(5'b11100, r, r, cpuPkg::regAddr_t'($urandom), 2'b00), 1'b1);
            issue("sle equal", regInstr(5'b11110, r, r, cpuPkg::regAddr_t'($urandom), 2'b00), 1'b1);
        end
    endtask

    task automatic memoryOps();
        cpuPkg::word_t base;
        logic [4:0]    off;
        for (int n = 0; n < 4; n++) begin
            base = cpuPkg::word_t'(32 + 2 * ($urandom % 48));
            off  = 5'($urandom) & 5'b11110;
            loadReg("mem setup", 3'd1, base);
            loadReg("mem setup", 3'd2, cpuPkg::word_t'($urandom));
            issue("st", immInstr(5'b10000, 3'd1, 3'd2, off), 1'b1);
            issue("ld", immInstr(5'b10001, 3'd1, 3'd3, off), 1'b1);
            loadReg("mem setup", 3'd4, cpuPkg::word_t'($urandom));
            issue("stu", immInstr(5'b10011, 3'd1, 3'd4, off), 1'b1);
            issue("ld after stu", immInstr(5'b10001, 3'd1, 3'd5, 5'd0), 1'b1);
        end
        issue("mem idle", '0, 1'b0);
        scanMemory("memory contents");
    endtask

    task automatic branchOps();
        logic [4:0]    ops [4];
        cpuPkg::word_t values [3];
        ops = '{5'b01100, 5'b01101, 5'b01110, 5'b01111};
        for (int k = 0; k < 4; k++) begin
            values = '{16'd0, cpuPkg::word_t'(1 + $urandom % 127),
                       cpuPkg::word_t'(16'h8000 | $urandom)};
            for (int m = 0; m < 3; m++) begin
                loadReg("branch setup", 3'd4, values[m]);
                issue($sformatf("branch op %b rs %h", ops[k], values[m]),
                      byteInstr(ops[k], 3'd4, 8'($urandom) & 8'hfe), 1'b1);
            end
        end
        issue("j", jumpInstr(5'b00100, 11'($urandom) & 11'h7fe), 1'b1);
        issue("jal", jumpInstr(5'b00110, 11'($urandom) & 11'h7fe), 1'b1);
        loadReg("jump setup", 3'd5, cpuPkg::word_t'($urandom) & 16'hfffe);
        issue("jr", byteInstr(5'b00101, 3'd5, 8'($urandom) & 8'hfe), 1'b1);
        issue("jalr", byteInstr(5'b00111, 3'd5, 8'($urandom) & 8'hfe), 1'b1);
        issue("jalr r7", byteInstr(5'b00111, 3'd7, 8'($urandom) & 8'hfe), 1'b1);
        // link register read back through add
        issue("link readback", regInstr(5'b11011, 3'd7, 3'd0, 3'd6, 2'b00), 1'b1);
    endtask

    task automatic haltAndErrors();
        issue("invalid opcode", {5'b00010, 11'($urandom)}, 1'b1);
        issue("invalid opcode", {5'b00011, 11'($urandom)}, 1'b1);
        for (int n = 0; n < 3; n++) begin
            issue("valid low", cpuPkg::instr_t'($urandom), 1'b0);
        end
        issue("halt", jumpInstr(5'b00000, 11'($urandom)), 1'b1);
        for (int n = 0; n < 3; n++) begin
            issue("after halt", regInstr(5'b11011, cpuPkg::regAddr_t'($urandom),
                  cpuPkg::regAddr_t'($urandom), cpuPkg::regAddr_t'($urandom), 2'b00), 1'b1);
        end
        issue("st after halt", immInstr(5'b10000, 3'd1, 3'd2, 5'd0), 1'b1);
        applyReset();
        for (int n = 0; n < 3; n++) begin
            issue("after reset", regInstr(5'b11011, cpuPkg::regAddr_t'($urandom),
                  cpuPkg::regAddr_t'($urandom), cpuPkg::regAddr_t'($urandom), 2'b00), 1'b1);
        end
        issue("after reset idle", '0, 1'b0);
    endtask

    initial begin
        seedVal    = $urandom(32'h6fa522ac);
        errorCount = 0;
        checkCount = 0;
        rstN       = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        for (int k = 0; k < 256; k++) begin
            mem[k]    = {8'(k), ~8'(k)} ^ 16'h3c5a;
            expMem[k] = mem[k];
        end
        applyReset();
        immediateOps();
        registerOps();
        memoryOps();
        branchOps();
        haltAndErrors();
        scanMemory("final memory");
        $display("checks %0d errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/cpuPkg.sv
verilog/control.sv
verilog/regFile.sv
verilog/alu.sv
verilog/execCore.sv
verif/tbExecCore.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the simulation log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    -f compile.f --top-module tbExecCore -o simExecCore > build.log 2>&1 \
    && ./obj_dir/simExecCore > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation did not pass, see sim.log"; exit 1; }
